/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_vcfg -f list.f
	./obj_dir/Vtb_vcfg

clean:
	rm -rf obj_dir

/* list.f */
vcfg_pkg.sv
vcfg_decode.sv
vcfg_xregs.sv
vcfg_calc.sv
vcfg_csr.sv
vcfg_ctrl.sv
vcfg_top.sv
tb_vcfg.sv

/* tb_vcfg.sv */
`timescale 1ns/1ns

module tb_vcfg;

    localparam int timeout_cycles = 400;    // directed tests need roughly 240 cycles
    localparam int wait_limit     = 8;      // cycles allowed between accept and writeback

    logic             clk;
    logic             rst_n;
    logic             instr_valid;
    vcfg_pkg::xlen_t  instr;
    logic             xw_en;
    vcfg_pkg::xaddr_t xw_addr;
    vcfg_pkg::xlen_t  xw_data;
    logic             busy;
    logic             illegal;
    logic             wb_valid;
    vcfg_pkg::xaddr_t wb_rd;
    vcfg_pkg::xlen_t  wb_data;
    vcfg_pkg::vl_t    vl;
    vcfg_pkg::sew_t   sew;
    logic             vill;

    // expected state, kept in step with every instruction
    vcfg_pkg::vl_t    exp_vl;
    vcfg_pkg::sew_t   exp_sew;
    logic             exp_vill;
    vcfg_pkg::xlen_t  xmirror [8];    // expected scalar register contents
    integer           seed;
    int               cycles;

    vcfg_top uut (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr(instr),
        .xw_en(xw_en), .xw_addr(xw_addr), .xw_data(xw_data),
        .busy(busy), .illegal(illegal),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .vl(vl), .sew(sew), .vill(vill)
    );

    always #20 clk = ~clk;    // 40 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_vl(input string name, input vcfg_pkg::vl_t got,
                              input vcfg_pkg::vl_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_sew(input string name, input vcfg_pkg::sew_t got,
                               input vcfg_pkg::sew_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_x(input string name, input vcfg_pkg::xlen_t got,
                             input vcfg_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // reference avl rules, cur is vl before the instruction
    function automatic vcfg_pkg::vl_t model_avl(input logic imm_form,
                                                input vcfg_pkg::xaddr_t rs1,
                                                input vcfg_pkg::xaddr_t rd,
                                                input logic [4:0] uimm,
                                                input vcfg_pkg::vl_t cur);
        if (imm_form) begin
            return vcfg_pkg::vl_t'(uimm);
        end else if (rs1 != '0) begin
            if (xmirror[rs1] > vcfg_pkg::vlmax) begin
                return vcfg_pkg::vl_t'(vcfg_pkg::vlmax);    // clip on the full word
            end
            return xmirror[rs1][vcfg_pkg::vl_bits-1:0];
        end else if (rd != '0) begin
            return vcfg_pkg::vl_t'(vcfg_pkg::vlmax);
        end
        return cur;    // rs1 and rd both x0
    endfunction

    task automatic write_xreg(input vcfg_pkg::xaddr_t addr, input vcfg_pkg::xlen_t data);
        @(negedge clk);
        xw_en   = 1'b1;
        xw_addr = addr;
        xw_data = data;
        @(negedge clk);
        xw_en = 1'b0;
        if (addr != '0) begin
            xmirror[addr] = data;    // x0 stays zero
        end
    endtask

    // one legal instruction, checked against exp_* at the writeback cycle
    task automatic run_config(input vcfg_pkg::xlen_t word, input vcfg_pkg::xaddr_t rd,
                              input logic wr);
        int lat;
        @(negedge clk);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk);    // accepting edge is behind us
        instr_valid = 1'b0;
        compare_bit("illegal", illegal, 1'b0);
        compare_bit("busy", busy, 1'b1);
        lat = 0;
        while (!wb_valid && lat < wait_limit) begin
            @(negedge clk);
            lat++;
            if (!wb_valid) begin
                compare_bit("busy", busy, 1'b1);
            end
        end
        if (!wb_valid) begin
            $display("no writeback pulse within %0d cycles of the accept", wait_limit);
            stop_on_error();
        end
        if (lat != 2) begin
            $display("writeback came %0d cycles after the accepting edge, expected 2", lat);
            stop_on_error();
        end
        compare_bit("busy", busy, 1'b0);
        compare_x("wb_rd", vcfg_pkg::xlen_t'(wb_rd), vcfg_pkg::xlen_t'(rd));
        compare_x("wb_data", wb_data, vcfg_pkg::xlen_t'(exp_vl));
        compare_bit("wb_en", uut.wb_en, wr);    // rd write enable of the register file
        compare_vl("vl", vl, exp_vl);
        compare_sew("sew", sew, exp_sew);
        compare_bit("vill", vill, exp_vill);
    endtask

    // an illegal word pulses illegal once and leaves the state alone
    task automatic run_illegal(input vcfg_pkg::xlen_t word);
        @(negedge clk);
        instr       = word;
        instr_valid = 1'b1;
        @(negedge clk);
        instr_valid = 1'b0;
        compare_bit("illegal", illegal, 1'b1);
        compare_bit("busy", busy, 1'b0);
        compare_bit("wb_valid", wb_valid, 1'b0);
        repeat (3) begin
            @(negedge clk);
            compare_bit("illegal", illegal, 1'b0);
            compare_bit("wb_valid", wb_valid, 1'b0);
            compare_bit("busy", busy, 1'b0);
        end
        compare_vl("vl", vl, exp_vl);
        compare_sew("sew", sew, exp_sew);
        compare_bit("vill", vill, exp_vill);
    endtask

    task automatic exec_vsetvli(input vcfg_pkg::xaddr_t rd, input vcfg_pkg::xaddr_t rs1,
                                input vcfg_pkg::sew_t s);
        vcfg_pkg::xlen_t noise;
        logic [10:0]     zimm;
        noise    = $random(seed);
        zimm     = {noise[10:6], s, noise[2:0]};    // lmul and policy bits are noise
        exp_vl   = model_avl(1'b0, rs1, rd, 5'd0, exp_vl);
        exp_sew  = s;
        exp_vill = 1'b0;
        run_config({1'b0, zimm, 2'b00, rs1, 3'b111, 2'b00, rd, 7'b1010111}, rd, rd != '0);
        if (rd != '0) begin
            xmirror[rd] = exp_vl;
        end
    endtask

    task automatic exec_vsetivli(input vcfg_pkg::xaddr_t rd, input logic [4:0] uimm,
                                 input vcfg_pkg::sew_t s);
        vcfg_pkg::xlen_t noise;
        logic [9:0]      zimm;
        noise    = $random(seed);
        zimm     = {noise[9:6], s, noise[2:0]};
        exp_vl   = model_avl(1'b1, 3'd0, rd, uimm, exp_vl);
        exp_sew  = s;
        exp_vill = 1'b0;
        run_config({2'b11, zimm, uimm, 3'b111, 2'b00, rd, 7'b1010111}, rd, rd != '0);
        if (rd != '0) begin
            xmirror[rd] = exp_vl;
        end
    endtask

    task automatic exec_vsetvl(input vcfg_pkg::xaddr_t rd, input vcfg_pkg::xaddr_t rs1,
                               input vcfg_pkg::xaddr_t rs2);
        exp_vl   = model_avl(1'b0, rs1, rd, 5'd0, exp_vl);
        exp_sew  = xmirror[rs2][5:3];
        exp_vill = xmirror[rs2][31];    // vtype from rs2, top bit is vill
        run_config({7'b1000000, 2'b00, rs2, 2'b00, rs1, 3'b111, 2'b00, rd, 7'b1010111},
                   rd, rd != '0);
        if (rd != '0) begin
            xmirror[rd] = exp_vl;
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        compare_bit("busy", busy, 1'b0);
        compare_bit("illegal", illegal, 1'b0);
        compare_bit("wb_valid", wb_valid, 1'b0);
        compare_vl("vl", vl, '0);
        compare_sew("sew", sew, '0);
        compare_bit("vill", vill, 1'b1);    // no configuration yet
    endtask

    task automatic vsetvli_avl_clip();
        vcfg_pkg::xlen_t  r;
        vcfg_pkg::xlen_t  avl;
        vcfg_pkg::xaddr_t rd;
        for (int i = 0; i < 6; i++) begin
            r  = $random(seed);
            rd = vcfg_pkg::xaddr_t'(2 + i % 3);
            if (i == 0) begin
                avl = 32'd2048;                   // exactly vlmax
            end else if (i % 2 == 1) begin
                avl = r | 32'h0000_1000;          // above vlmax, low bits arbitrary
            end else begin
                avl = r % 32'd2047 + 32'd1;       // 1..2047
            end
            write_xreg(3'd1, avl);
            write_xreg(rd, '0);                   // so a missing writeback shows up
            exec_vsetvli(rd, 3'd1, r[15:13]);
            exec_vsetvli(3'd0, rd, r[15:13]);     // rd read back as the avl
        end
    endtask

    task automatic x0_operands();
        exec_vsetvli(3'd3, 3'd0, 3'd2);           // rs1 x0, rd live
        compare_vl("vl", vl, vcfg_pkg::vl_t'(vcfg_pkg::vlmax));
        exec_vsetivli(3'd0, 5'd13, 3'd1);
        exec_vsetvli(3'd0, 3'd0, 3'd3);           // only vtype moves
        compare_vl("vl", vl, 12'd13);
        compare_sew("sew", sew, 3'd3);
    endtask

    task automatic vsetivli_uimm_sweep();
        for (int u = 0; u < 32; u++) begin
            exec_vsetivli(vcfg_pkg::xaddr_t'(u % 8), 5'(u), vcfg_pkg::sew_t'(u * 3));
        end
    endtask

    task automatic vsetvl_vill();
        vcfg_pkg::xlen_t r;
        r = $random(seed);
        write_xreg(3'd6, {1'b1, r[30:6], 3'b101, r[2:0]});
        exec_vsetvl(3'd7, 3'd1, 3'd6);
        compare_bit("vill", vill, 1'b1);
        compare_sew("sew", sew, 3'd5);
        exec_vsetvli(3'd0, 3'd1, 3'd0);           // immediate vtype is always valid
        compare_bit("vill", vill, 1'b0);
    endtask

    task automatic illegal_words();
        run_illegal({1'b0, 11'h018, 5'd1, 3'b110, 5'd2, 7'b1010111});    // funct3
        run_illegal({7'b1000001, 5'd6, 5'd1, 3'b111, 5'd2, 7'b1010111}); // vsetvl funct7
        run_illegal({1'b0, 11'h018, 5'd1, 3'b111, 5'd9, 7'b1010111});    // rd is x9
    endtask

    initial begin
        seed        = 32'heaa6_30a6;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        xw_en       = 1'b0;
        xw_addr     = '0;
        xw_data     = '0;
        cycles      = 0;
        exp_vl      = '0;
        exp_sew     = '0;
        exp_vill    = 1'b1;
        for (int i = 0; i < 8; i++) begin
            xmirror[i] = '0;
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        check_reset_state();
        vsetvli_avl_clip();
        x0_operands();
        vsetivli_uimm_sweep();
        vsetvl_vill();
        illegal_words();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* vcfg_calc.sv */
`timescale 1ns/1ns

module vcfg_calc (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,         // high in st_exec
    input  vcfg_pkg::vcfg_dec_t dec,
    input  vcfg_pkg::xlen_t     rs1_val,
    input  vcfg_pkg::xlen_t     rs2_val,
    input  vcfg_pkg::vl_t       cur_vl,     // kept when rs1 and rd are both x0
    output vcfg_pkg::vcfg_res_t res
);

    vcfg_pkg::xlen_t vtype_nxt;
    vcfg_pkg::sew_t  sew_nxt;
    logic            vill_nxt;
    vcfg_pkg::vl_t   avl_nxt;
    logic            rs1_big;

    // register form takes vtype from rs2, immediates from zimm
    assign vtype_nxt = (dec.cfg_type == vcfg_pkg::cfg_vsetvl) ? rs2_val
                                                               : vcfg_pkg::xlen_t'(dec.zimm);
    assign sew_nxt   = vtype_nxt[5:3];
    assign vill_nxt  = vtype_nxt[vcfg_pkg::xlen-1];    // zero for zimm, top bits unused

    // clip over the whole word, not just the low vl bits
    assign rs1_big = (rs1_val > vcfg_pkg::xlen_t'(vcfg_pkg::vlmax));

    always_comb begin
        if (dec.cfg_type == vcfg_pkg::cfg_vsetivli) begin
            avl_nxt = vcfg_pkg::vl_t'(dec.uimm);               // 0..31
        end else if (!dec.avl_set[0]) begin
            avl_nxt = rs1_big ? vcfg_pkg::vl_t'(vcfg_pkg::vlmax)
                              : rs1_val[vcfg_pkg::vl_bits-1:0];
        end else if (!dec.avl_set[1]) begin
            avl_nxt = vcfg_pkg::vl_t'(vcfg_pkg::vlmax);       // rs1 x0, rd live
        end else begin
            avl_nxt = cur_vl;                                  // only vtype changes
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            if (en) begin
                res.avl  <= avl_nxt;
                res.sew  <= sew_nxt;
                res.vill <= vill_nxt;
            end
            // flags last one cycle, ctrl and csr sample them in st_wb
            res.vtype_upd <= en;
            res.new_vl    <= en & ~(&dec.avl_set);
        end
    end

endmodule

/* vcfg_csr.sv */
`timescale 1ns/1ns

module vcfg_csr (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,        // high in st_wb
    input  vcfg_pkg::vcfg_res_t res,
    output vcfg_pkg::vl_t       vl,
    output vcfg_pkg::sew_t      sew,
    output logic                vill,
    output vcfg_pkg::xlen_t     wb_data
);

    vcfg_pkg::vl_t  vl_q;
    vcfg_pkg::sew_t sew_q;
    logic           vill_q;

    // out of reset there is no valid configuration
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vl_q   <= '0;
            sew_q  <= '0;
            vill_q <= 1'b1;
        end else if (en) begin
            vl_q <= res.avl;
            if (res.vtype_upd) begin
                sew_q  <= res.sew;
                vill_q <= res.vill;
            end
        end
    end

    assign vl   = vl_q;
    assign sew  = sew_q;
    assign vill = vill_q;

    // rd gets the new vl, zero extended
    // res.avl still holds through the writeback cycle
    assign wb_data = vcfg_pkg::xlen_t'(res.avl);

    // every avl path in calc is clipped
    a_vl_max : assert property (
        @(posedge clk) disable iff (!rst_n)
        vl_q <= vcfg_pkg::vl_t'(vcfg_pkg::vlmax)
    ) else $error("vcfg_csr: vl %0d above vlmax", vl_q);

endmodule

/* vcfg_ctrl.sv */
`timescale 1ns/1ns

module vcfg_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,      // one cycle strobe
    input  vcfg_pkg::vcfg_dec_t dec_in,           // straight from the decoder
    input  logic                illegal_instr,
    input  logic                new_vl,           // valid in st_wb when it comes from calc
    output vcfg_pkg::vcfg_dec_t dec,              // latched instruction
    output logic                calc_en,
    output logic                csr_en,
    output logic                busy,
    output logic                illegal,
    output logic                wb_valid,
    output logic                wb_en,
    output vcfg_pkg::xaddr_t    wb_rd
);

    vcfg_pkg::ctrl_state_e state_q;
    vcfg_pkg::ctrl_state_e state_d;
    logic                  accept;

    assign accept = instr_valid && (state_q == vcfg_pkg::st_idle);

    // illegal words never leave idle in the fixed three state walk
    always_comb begin
        state_d = state_q;
        case (state_q)
            vcfg_pkg::st_idle: if (accept && !illegal_instr) state_d = vcfg_pkg::st_exec;
            vcfg_pkg::st_exec: state_d = vcfg_pkg::st_wb;
            vcfg_pkg::st_wb:   state_d = vcfg_pkg::st_idle;
            default:           state_d = vcfg_pkg::st_idle;
        endcase
    end

    assign calc_en = (state_q == vcfg_pkg::st_exec);
    assign csr_en  = (state_q == vcfg_pkg::st_wb);
    assign busy    = (state_q != vcfg_pkg::st_idle);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= vcfg_pkg::st_idle;
            dec      <= '0;
            illegal  <= 1'b0;
            wb_valid <= 1'b0;
            wb_en    <= 1'b0;
            wb_rd    <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                dec <= dec_in;                           // holds until the next accept
            end
            illegal  <= accept & illegal_instr;          // one cycle pulse
            wb_valid <= csr_en;                          // lines up with the new vl
            wb_en    <= csr_en & new_vl & (dec.rd != '0);
            if (csr_en) begin
                wb_rd <= dec.rd;
            end
        end
    end

    // the source must wait out busy as there is no back-pressure
    a_no_strobe_busy : assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> !instr_valid
    ) else $error("vcfg_ctrl: instr_valid while busy");

endmodule

/* vcfg_decode.sv */
`timescale 1ns/1ns

module vcfg_decode (
    input  vcfg_pkg::xlen_t     instr,
    output vcfg_pkg::vcfg_dec_t dec,
    output logic                illegal_instr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rd_f;
    logic [4:0] rs1_f;
    logic [4:0] rs2_f;
    logic       is_vli;        // vsetvli
    logic       is_vli_imm;    // vsetivli
    logic       is_vl;         // vsetvl
    logic       bad_reg;

    // standard V field split
    assign opcode = instr[6:0];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];

    assign is_vli     = ~instr[31];
    assign is_vli_imm = (instr[31:30] == 2'b11);
    assign is_vl      = (instr[31:25] == vcfg_pkg::f7_vsetvl);

    // only x0..x7 exist, rs1 is uimm for vsetivli, rs2 is zimm for vsetvli
    assign bad_reg = (rd_f[4:3] != 2'b00)
                   | (~is_vli_imm & (rs1_f[4:3] != 2'b00))
                   | (is_vl & (rs2_f[4:3] != 2'b00));

    always_comb begin
        dec            = '0;
        dec.rd         = rd_f[2:0];
        dec.rs1        = rs1_f[2:0];
        dec.rs2        = rs2_f[2:0];
        dec.avl_set[1] = (rd_f == 5'd0);
        if (is_vli_imm) begin
            dec.cfg_type   = vcfg_pkg::cfg_vsetivli;
            dec.uimm       = rs1_f;                     // avl straight from the field
            dec.zimm       = {1'b0, instr[29:20]};      // 10 bit zimm here
            dec.avl_set[0] = 1'b0;                      // no rs1 read
        end else begin
            dec.avl_set[0] = (rs1_f == 5'd0);
            if (is_vl) begin
                dec.cfg_type = vcfg_pkg::cfg_vsetvl;    // vtype comes from rs2
            end else begin
                dec.cfg_type = vcfg_pkg::cfg_vsetvli;
                dec.zimm     = instr[30:20];
            end
        end
    end

    assign illegal_instr = (opcode != vcfg_pkg::op_vcfg)
                         | (funct3 != vcfg_pkg::f3_vcfg)
                         | ~(is_vli | is_vli_imm | is_vl)    // 10xxxxx other than 1000000
                         | bad_reg;

    // a known word must give a fully known decode
    always_comb begin
        if (!$isunknown(instr)) begin
            assert final (!$isunknown({dec, illegal_instr}))
                else $error("vcfg_decode: unknown output for instr %h", instr);
        end
    end

endmodule

/* vcfg_pkg.sv */
package vcfg_pkg;

    // sizes of the fixed configuration
    localparam int xlen       = 32;                    // scalar word width
    localparam int vl_bits    = 12;                    // vl and avl width
    localparam int vlmax      = 2048;                  // VLEN 16384 at 8 bit elements
    localparam int xreg_count = 8;                     // reduced scalar file
    localparam int xaddr_bits = $clog2(xreg_count);    // 3 bit register index
    localparam int sew_bits   = 3;                     // vtype[5:3]

    // encoding of the config instructions
    localparam logic [6:0] op_vcfg   = 7'b1010111;     // OP-V major opcode
    localparam logic [2:0] f3_vcfg   = 3'b111;         // OPCFG
    localparam logic [6:0] f7_vsetvl = 7'b1000000;     // register form

    typedef logic [xlen-1:0]       xlen_t;     // scalar value or instruction word
    typedef logic [vl_bits-1:0]    vl_t;       // vl or avl
    typedef logic [sew_bits-1:0]   sew_t;      // sew code
    typedef logic [xaddr_bits-1:0] xaddr_t;    // register index

    // config type, 2'b10 has no instruction here
    typedef enum logic [1:0] {
        cfg_vsetvli  = 2'b00,
        cfg_vsetvl   = 2'b01,
        cfg_vsetivli = 2'b11
    } cfg_type_e;

    typedef enum logic [1:0] {
        st_idle = 2'b00,    // waiting for a strobe
        st_exec = 2'b01,    // calc registers the result
        st_wb   = 2'b10     // state update and rd writeback
    } ctrl_state_e;

    // decoded instruction
    typedef struct packed {
        cfg_type_e   cfg_type;
        xaddr_t      rs1;
        xaddr_t      rs2;
        xaddr_t      rd;
        logic [4:0]  uimm;       // avl of vsetivli
        logic [10:0] zimm;       // vtype immediate, zero extended for vsetivli
        logic [1:0]  avl_set;    // [0] rs1 is x0, [1] rd is x0
    } vcfg_dec_t;

    // calc result, consumed by the state block and ctrl
    typedef struct packed {
        vl_t  avl;
        sew_t sew;
        logic vill;
        logic vtype_upd;    // sew and vill are fresh
        logic new_vl;       // rd gets the new vl
    } vcfg_res_t;

endpackage

/* vcfg_top.sv */
`timescale 1ns/1ns

module vcfg_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid,
    input  vcfg_pkg::xlen_t  instr,
    input  logic             xw_en,        // scalar fill, idle only
    input  vcfg_pkg::xaddr_t xw_addr,
    input  vcfg_pkg::xlen_t  xw_data,
    output logic             busy,
    output logic             illegal,
    output logic             wb_valid,
    output vcfg_pkg::xaddr_t wb_rd,
    output vcfg_pkg::xlen_t  wb_data,
    output vcfg_pkg::vl_t    vl,           // architectural state
    output vcfg_pkg::sew_t   sew,
    output logic             vill
);

    vcfg_pkg::vcfg_dec_t dec_raw;    // combinational decode
    vcfg_pkg::vcfg_dec_t dec_q;      // latched by ctrl
    vcfg_pkg::vcfg_res_t res;
    vcfg_pkg::xlen_t     rs1_val;
    vcfg_pkg::xlen_t     rs2_val;
    logic                illegal_instr;
    logic                calc_en;
    logic                csr_en;
    logic                wb_en;

    vcfg_decode u_decode (
        .instr(instr), .dec(dec_raw), .illegal_instr(illegal_instr)
    );

    vcfg_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .dec_in(dec_raw), .illegal_instr(illegal_instr),
        .new_vl(res.new_vl), .dec(dec_q),
        .calc_en(calc_en), .csr_en(csr_en), .busy(busy), .illegal(illegal),
        .wb_valid(wb_valid), .wb_en(wb_en), .wb_rd(wb_rd)
    );

    // operands read from the latched fields
    vcfg_xregs u_xregs (
        .clk(clk), .rst_n(rst_n),
        .xw_en(xw_en), .xw_addr(xw_addr), .xw_data(xw_data),
        .wb_en(wb_en), .wb_addr(wb_rd), .wb_data(wb_data),
        .rs1_addr(dec_q.rs1), .rs2_addr(dec_q.rs2),
        .rs1_val(rs1_val), .rs2_val(rs2_val)
    );

    vcfg_calc u_calc (
        .clk(clk), .rst_n(rst_n), .en(calc_en), .dec(dec_q),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .cur_vl(vl), .res(res)
    );

    vcfg_csr u_csr (
        .clk(clk), .rst_n(rst_n), .en(csr_en), .res(res),
        .vl(vl), .sew(sew), .vill(vill), .wb_data(wb_data)
    );

endmodule

/* vcfg_xregs.sv */
`timescale 1ns/1ns

module vcfg_xregs (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             xw_en,       // external fill port
    input  vcfg_pkg::xaddr_t xw_addr,
    input  vcfg_pkg::xlen_t  xw_data,
    input  logic             wb_en,       // vl writeback port
    input  vcfg_pkg::xaddr_t wb_addr,
    input  vcfg_pkg::xlen_t  wb_data,
    input  vcfg_pkg::xaddr_t rs1_addr,
    input  vcfg_pkg::xaddr_t rs2_addr,
    output vcfg_pkg::xlen_t  rs1_val,
    output vcfg_pkg::xlen_t  rs2_val
);

    vcfg_pkg::xlen_t regs [vcfg_pkg::xreg_count];

    // x0 is never written, writes to it fall away
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < vcfg_pkg::xreg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (xw_en && (xw_addr != '0)) begin
            regs[xw_addr] <= xw_data;
        end else if (wb_en && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;    // new vl into rd
        end
    end

    // async reads, x0 hardwired
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // fill port is only used while idle, never against a writeback
    a_one_writer : assert property (
        @(posedge clk) disable iff (!rst_n) !(xw_en && wb_en)
    ) else $error("vcfg_xregs: external write collides with writeback");

endmodule
